/* source/simdPkg.sv */
package simdPkg;

    typedef logic [15:0] word_t;
    typedef logic [3:0] nibble_t;
    typedef logic [17:0] instr_t;
    typedef logic [5:0] opcode_t;
    typedef logic [9:0] imm_t;
    typedef logic [1:0] regIdx_t;

    // bank select and element width
    typedef enum logic [1:0]
    {
        modeH,
        modeO,
        modeQ
    } laneMode_t;

    typedef enum logic [2:0]
    {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluNot,
        aluPass // forwards operand b, used by set
    } aluOp_t;

    typedef enum logic [2:0]
    {
        stIdle,
        stFetch,
        stDecode,
        stExecute,
        stMemory,
        stWriteback,
        stHalt
    } cpuState_t;

    // group bases, mode is the offset from the base
    localparam opcode_t OpAddBase = 6'd0;
    localparam opcode_t OpSubBase = 6'd6;
    localparam opcode_t OpAndBase = 6'd27;
    localparam opcode_t OpOrBase = 6'd30;
    localparam opcode_t OpNotBase = 6'd33;
    localparam opcode_t OpLoadBase = 6'd38;
    localparam opcode_t OpStoreBase = 6'd41;
    localparam opcode_t OpSetBase = 6'd44;
    localparam opcode_t OpHalt = 6'd63;

    localparam int SliceCount = 4;

endpackage

/* source/cpuControl.sv */
module cpuControl
#(
    parameter int AddrWidth = 10
)
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 isHalt,
    input  logic                 isLoad,
    input  logic                 isStore,
    input  simdPkg::imm_t        imm,
    input  simdPkg::word_t       storeData,
    output simdPkg::cpuState_t   state,
    output logic [AddrWidth-1:0] pc,
    output logic [AddrWidth-1:0] dataAddr,
    output logic                 dataR,
    output logic                 dataW,
    output simdPkg::word_t       dataOut,
    output logic                 done
);
    import simdPkg::*;

    assign done = (state == stHalt);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= stIdle;
            pc    <= '0;
        end
        else
        begin
            case (state)
                stIdle:      state <= stFetch;
                stFetch:     state <= stDecode;
                stDecode:    state <= isHalt ? stHalt : stExecute;
                stExecute:   state <= stMemory;
                stMemory:    state <= stWriteback;
                stWriteback:
                begin
                    state <= stFetch;
                    pc    <= pc + AddrWidth'(1);
                end
                default:     state <= stHalt; // stays until reset
            endcase
        end
    end

    // strobes span memory and writeback
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            dataR    <= 1'b0;
            dataW    <= 1'b0;
            dataAddr <= '0;
        end
        else if (state == stExecute)
        begin
            dataR <= isLoad;
            dataW <= isStore;
            if (isLoad || isStore)
            begin
                dataAddr <= imm[AddrWidth-1:0];
            end
        end
        else if (state == stWriteback)
        begin
            dataR <= 1'b0;
            dataW <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == stExecute && isStore)
        begin
            dataOut <= storeData;
        end
    end

endmodule

/* source/instrDecode.sv */
module instrDecode
(
    input  logic               clk,
    input  logic               rst,
    input  simdPkg::cpuState_t state,
    input  simdPkg::instr_t    instruction,
    output simdPkg::aluOp_t    aluOp,
    output simdPkg::laneMode_t laneMode,
    output simdPkg::regIdx_t   srcA,
    output simdPkg::regIdx_t   srcB,
    output simdPkg::regIdx_t   dest,
    output logic               useImm,
    output simdPkg::imm_t      imm,
    output logic               writeEn,
    output logic               isLoad,
    output logic               isStore,
    output logic               isHalt
);
    import simdPkg::*;

    opcode_t opcode;
    opcode_t offset;
    regIdx_t rA;
    regIdx_t rB;
    regIdx_t rC;
    aluOp_t nextAluOp;
    laneMode_t nextMode;
    regIdx_t nextSrcA;
    regIdx_t nextDest;
    logic nextUseImm;
    logic nextWriteEn;
    logic nextLoad;
    logic nextStore;

    assign opcode = instruction[17:12];
    assign rA = instruction[11:10];
    assign rB = instruction[3:2];
    assign rC = instruction[1:0];

    // unregistered so decode can go straight to halt
    assign isHalt = (state == stDecode) && (opcode == OpHalt);

    always_comb
    begin
        nextAluOp   = aluPass;
        nextSrcA    = rA;
        nextDest    = rA;
        nextUseImm  = 1'b0;
        nextWriteEn = 1'b0;
        nextLoad    = 1'b0;
        nextStore   = 1'b0;
        offset      = '0;
        if (opcode < OpSubBase + 6'd6) // add and sub
        begin
            nextAluOp   = (opcode < OpSubBase) ? aluAdd : aluSub;
            offset      = (opcode < OpSubBase) ? opcode - OpAddBase : opcode - OpSubBase;
            nextWriteEn = 1'b1;
            if (offset >= 6'd3)
            begin
                offset     = offset - 6'd3; // immediate form
                nextUseImm = 1'b1;
            end
            else
            begin
                nextSrcA = rB;
                nextDest = rB;
            end
        end
        else if (opcode >= OpAndBase && opcode < OpNotBase)
        begin
            nextAluOp   = (opcode < OpOrBase) ? aluAnd : aluOr;
            offset      = (opcode < OpOrBase) ? opcode - OpAndBase : opcode - OpOrBase;
            nextSrcA    = rB;
            nextDest    = rB;
            nextWriteEn = 1'b1;
        end
        else if (opcode >= OpNotBase && opcode < OpNotBase + 6'd3)
        begin
            nextAluOp   = aluNot;
            offset      = opcode - OpNotBase;
            nextSrcA    = rC;
            nextDest    = rC;
            nextWriteEn = 1'b1;
        end
        else if (opcode >= OpLoadBase && opcode < OpStoreBase)
        begin
            offset      = opcode - OpLoadBase;
            nextWriteEn = 1'b1;
            nextLoad    = 1'b1;
        end
        else if (opcode >= OpStoreBase && opcode < OpSetBase)
        begin
            offset    = opcode - OpStoreBase;
            nextStore = 1'b1;
        end
        else if (opcode >= OpSetBase && opcode < OpSetBase + 6'd3)
        begin
            offset      = opcode - OpSetBase;
            nextUseImm  = 1'b1;
            nextWriteEn = 1'b1;
        end
        nextMode = laneMode_t'(offset[1:0]);
    end

    always_ff @(posedge clk)
    begin
        if (rst || state == stIdle || state == stFetch)
        begin
            aluOp    <= aluPass;
            laneMode <= modeH;
            srcA     <= '0;
            srcB     <= '0;
            dest     <= '0;
            useImm   <= 1'b0;
            imm      <= '0;
            writeEn  <= 1'b0;
            isLoad   <= 1'b0;
            isStore  <= 1'b0;
        end
        else if (state == stDecode)
        begin
            aluOp    <= nextAluOp;
            laneMode <= nextMode;
            srcA     <= nextSrcA;
            srcB     <= rC;
            dest     <= nextDest;
            useImm   <= nextUseImm;
            imm      <= instruction[9:0];
            writeEn  <= nextWriteEn;
            isLoad   <= nextLoad;
            isStore  <= nextStore;
        end
    end

endmodule

/* source/operandSelect.sv */
module operandSelect
(
    input  simdPkg::laneMode_t laneMode,
    input  simdPkg::regIdx_t   srcA,
    input  simdPkg::regIdx_t   srcB,
    input  logic               useImm,
    input  simdPkg::imm_t      imm,
    input  simdPkg::word_t     bankH [4],
    input  simdPkg::word_t     bankO [3],
    input  simdPkg::word_t     bankQ [3],
    output simdPkg::word_t     opA,
    output simdPkg::word_t     opB
);
    import simdPkg::*;

    word_t regA;
    word_t regB;
    word_t immWord;

    always_comb
    begin
        case (laneMode)
            modeO:
            begin
                regA    = (srcA == 2'd3) ? '0 : bankO[srcA]; // index 3 reads zero
                regB    = (srcB == 2'd3) ? '0 : bankO[srcB];
                immWord = {2{imm[7:0]}};
            end
            modeQ:
            begin
                regA    = (srcA == 2'd3) ? '0 : bankQ[srcA];
                regB    = (srcB == 2'd3) ? '0 : bankQ[srcB];
                immWord = {4{imm[3:0]}};
            end
            default:
            begin
                regA    = bankH[srcA];
                regB    = bankH[srcB];
                immWord = {6'b0, imm};
            end
        endcase
    end

    assign opA = regA;
    assign opB = useImm ? immWord : regB;

endmodule

/* source/laneSlice.sv */
module laneSlice
#(
    parameter int SliceIndex = 0
)
(
    input  simdPkg::aluOp_t    aluOp,
    input  simdPkg::laneMode_t laneMode,
    input  simdPkg::nibble_t   a,
    input  simdPkg::nibble_t   b,
    input  logic               carryIn,
    output simdPkg::nibble_t   result,
    output logic               carryOut
);
    import simdPkg::*;

    logic startsElement;
    logic carry;
    nibble_t bEff;
    logic [4:0] sum;

    always_comb
    begin
        case (laneMode)
            modeO:   startsElement = (SliceIndex % 2 == 0);
            modeQ:   startsElement = 1'b1;
            default: startsElement = (SliceIndex == 0);
        endcase
    end

    // fresh carry at an element boundary, 1 gives two's complement on sub
    assign carry = startsElement ? (aluOp == aluSub) : carryIn;
    assign bEff = (aluOp == aluSub) ? ~b : b;
    assign sum = {1'b0, a} + {1'b0, bEff} + {4'b0, carry};
    assign carryOut = sum[4];

    always_comb
    begin
        case (aluOp)
            aluAdd, aluSub: result = sum[3:0];
            aluAnd:         result = a & b;
            aluOr:          result = a | b;
            aluNot:         result = ~a;
            default:        result = b;
        endcase
    end

endmodule

/* source/simdRegFile.sv */
module simdRegFile
(
    input  logic               clk,
    input  logic               rst,
    input  simdPkg::cpuState_t state,
    input  simdPkg::laneMode_t laneMode,
    input  simdPkg::regIdx_t   dest,
    input  logic               writeEn,
    input  logic               isLoad,
    input  simdPkg::word_t     sliceResult,
    input  simdPkg::word_t     dataIn,
    output simdPkg::word_t     bankH [4],
    output simdPkg::word_t     bankO [3],
    output simdPkg::word_t     bankQ [3]
);
    import simdPkg::*;

    word_t resultReg;
    word_t wbData;

    assign wbData = isLoad ? dataIn : resultReg;

    always_ff @(posedge clk)
    begin
        if (state == stExecute)
        begin
            resultReg <= sliceResult; // alu result held for writeback
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            bankH <= '{default: '0};
            bankO <= '{default: '0};
            bankQ <= '{default: '0};
        end
        else if (state == stWriteback && writeEn)
        begin
            case (laneMode)
                modeO:
                begin
                    if (dest != 2'd3)
                    begin
                        bankO[dest] <= wbData;
                    end
                end
                modeQ:
                begin
                    if (dest != 2'd3) // no fourth entry
                    begin
                        bankQ[dest] <= wbData;
                    end
                end
                default:
                begin
                    bankH[dest] <= wbData;
                end
            endcase
        end
    end

endmodule

/* source/simdCpuTop.sv */
module simdCpuTop
#(
    parameter int AddrWidth = 10
)
(
    input  logic                 clk,
    input  logic                 rst,
    input  simdPkg::instr_t      instructionIn,
    input  simdPkg::word_t       dataIn,
    output simdPkg::word_t       dataOut,
    output logic [AddrWidth-1:0] instructionAddr,
    output logic [AddrWidth-1:0] dataAddr,
    output logic                 dataR,
    output logic                 dataW,
    output logic                 done
);
    import simdPkg::*;

    cpuState_t state;
    aluOp_t aluOp;
    laneMode_t laneMode;
    regIdx_t srcA;
    regIdx_t srcB;
    regIdx_t dest;
    logic useImm;
    imm_t imm;
    logic writeEn;
    logic isLoad;
    logic isStore;
    logic isHalt;
    word_t opA;
    word_t opB;
    word_t sliceResult;
    word_t bankH [4];
    word_t bankO [3];
    word_t bankQ [3];
    logic [SliceCount:0] carry; // top bit is the dropped element carry

    assign carry[0] = 1'b0; // slice 0 always starts fresh

    cpuControl #(
        .AddrWidth(AddrWidth)
    ) control (
        .clk(clk),
        .rst(rst),
        .isHalt(isHalt),
        .isLoad(isLoad),
        .isStore(isStore),
        .imm(imm),
        .storeData(opA),
        .state(state),
        .pc(instructionAddr),
        .dataAddr(dataAddr),
        .dataR(dataR),
        .dataW(dataW),
        .dataOut(dataOut),
        .done(done)
    );

    instrDecode decode (
        .clk(clk),
        .rst(rst),
        .state(state),
        .instruction(instructionIn),
        .aluOp(aluOp),
        .laneMode(laneMode),
        .srcA(srcA),
        .srcB(srcB),
        .dest(dest),
        .useImm(useImm),
        .imm(imm),
        .writeEn(writeEn),
        .isLoad(isLoad),
        .isStore(isStore),
        .isHalt(isHalt)
    );

    operandSelect operands (
        .laneMode(laneMode),
        .srcA(srcA),
        .srcB(srcB),
        .useImm(useImm),
        .imm(imm),
        .bankH(bankH),
        .bankO(bankO),
        .bankQ(bankQ),
        .opA(opA),
        .opB(opB)
    );

    for (genvar i = 0; i < SliceCount; i++)
    begin : gSlice
        laneSlice #(
            .SliceIndex(i)
        ) slice (
            .aluOp(aluOp),
            .laneMode(laneMode),
            .a(opA[4*i +: 4]),
            .b(opB[4*i +: 4]),
            .carryIn(carry[i]),
            .result(sliceResult[4*i +: 4]),
            .carryOut(carry[i+1])
        );
    end

    simdRegFile regFile (
        .clk(clk),
        .rst(rst),
        .state(state),
        .laneMode(laneMode),
        .dest(dest),
        .writeEn(writeEn),
        .isLoad(isLoad),
        .sliceResult(sliceResult),
        .dataIn(dataIn),
        .bankH(bankH),
        .bankO(bankO),
        .bankQ(bankQ)
    );

endmodule

/* sim/simdCpuProps.sv */
module simdCpuProps
#(
    parameter int AddrWidth = 10
)
(
    input logic                 clk,
    input logic                 rst,
    input logic                 dataR,
    input logic                 dataW,
    input logic [AddrWidth-1:0] dataAddr,
    input logic                 done
);
    timeunit 1ns;
    timeprecision 1ns;

    noOverlap: assert property (@(posedge clk) disable iff (rst) !(dataR && dataW))
        else $error("dataR and dataW high together");

    // address held over memory and writeback
    addrHold: assert property (@(posedge clk) disable iff (rst)
        ((dataR || dataW) && $past(dataR || dataW)) |-> $stable(dataAddr))
        else $error("dataAddr changed while a strobe was high");

    quietWhenDone: assert property (@(posedge clk) disable iff (rst) done |-> !(dataR || dataW))
        else $error("strobe raised while done is high");

    doneSticky: assert property (@(posedge clk) disable iff (rst) done |=> done)
        else $error("done dropped before reset");

endmodule

bind cpuControl simdCpuProps #(
    .AddrWidth(AddrWidth)
) props_i (
    .clk(clk),
    .rst(rst),
    .dataR(dataR),
    .dataW(dataW),
    .dataAddr(dataAddr),
    .done(done)
);

/* sim/simdCpuTb.sv */
module simdCpuTb;
    timeunit 1ns;
    timeprecision 1ns;
    import simdPkg::*;

    localparam int AddrWidth = 10;
    localparam int MemDepth = 1 << AddrWidth;
    localparam int ResetCycles = 16;
    localparam int StoreBase = 512; // loads stay below, stores above

    typedef logic [AddrWidth-1:0] addr_t;

    logic clk;
    logic rst;
    instr_t instructionIn;
    word_t dataIn;
    word_t dataOut;
    addr_t instructionAddr;
    addr_t dataAddr;
    logic dataR;
    logic dataW;
    logic done;

    instr_t prog [MemDepth];
    word_t dataMem [MemDepth];
    word_t mH [4]; // model banks, entry 3 of O and Q stays zero
    word_t mO [4];
    word_t mQ [4];
    addr_t expStoreAddr [$];
    word_t expStoreData [$];
    addr_t expLoadAddr [$];
    addr_t haltAddr;
    int progLen = 0;
    int nextStore = StoreBase;
    int seed = 83235;
    int cycle = 0;
    int limit = 0;
    int mismatchCount = 0;
    int otherCount = 0;
    int haltFetchCycle = -1;
    logic pcMoved = 1'b0;
    logic doneSeen = 1'b0;
    logic prevR = 1'b0;
    logic prevW = 1'b0;

    simdCpuTop #(
        .AddrWidth(AddrWidth)
    ) dut_i (
        .clk(clk),
        .rst(rst),
        .instructionIn(instructionIn),
        .dataIn(dataIn),
        .dataOut(dataOut),
        .instructionAddr(instructionAddr),
        .dataAddr(dataAddr),
        .dataR(dataR),
        .dataW(dataW),
        .done(done)
    );

    // both memories answer combinationally
    assign instructionIn = prog[instructionAddr];
    assign dataIn = dataMem[dataAddr];

    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
        if (dataW)
        begin
            dataMem[dataAddr] = dataOut;
        end
    end

    // expected result, element by element
    function automatic word_t laneCompute(aluOp_t op, laneMode_t mode, word_t a, word_t b);
        int width;
        int e;
        word_t mask;
        word_t ea;
        word_t eb;
        word_t er;
        word_t res;
        width = (mode == modeH) ? 16 : (mode == modeO) ? 8 : 4;
        mask = word_t'((32'd1 << width) - 1);
        res = '0;
        for (e = 0; e < 16 / width; e++)
        begin
            ea = (a >> (e * width)) & mask;
            eb = (b >> (e * width)) & mask;
            case (op)
                aluAdd:  er = (ea + eb) & mask; // carry out of the element is lost
                aluSub:  er = (ea - eb) & mask;
                aluAnd:  er = ea & eb;
                aluOr:   er = ea | eb;
                aluNot:  er = ~ea & mask;
                default: er = eb;
            endcase
            res = res | word_t'(er << (e * width));
        end
        return res;
    endfunction

    function automatic word_t immOperand(laneMode_t mode, imm_t imm);
        case (mode)
            modeO:   return {imm[7:0], imm[7:0]};
            modeQ:   return {imm[3:0], imm[3:0], imm[3:0], imm[3:0]};
            default: return {6'b0, imm};
        endcase
    endfunction

    function automatic opcode_t withMode(opcode_t base, laneMode_t mode);
        case (mode)
            modeO:   return base + 6'd1;
            modeQ:   return base + 6'd2;
            default: return base;
        endcase
    endfunction

    function automatic word_t readReg(laneMode_t mode, regIdx_t idx);
        case (mode)
            modeO:   return mO[idx];
            modeQ:   return mQ[idx];
            default: return mH[idx];
        endcase
    endfunction

    function automatic imm_t randImm();
        return imm_t'($random(seed));
    endfunction

    task automatic writeReg(laneMode_t mode, regIdx_t idx, word_t val);
        case (mode)
            modeO:   if (idx != 2'd3) mO[idx] = val;
            modeQ:   if (idx != 2'd3) mQ[idx] = val;
            default: mH[idx] = val;
        endcase
    endtask

    task automatic emit(instr_t instr);
        prog[progLen] = instr;
        progLen++;
    endtask

    task automatic setReg(laneMode_t mode, regIdx_t r, imm_t imm);
        emit({withMode(OpSetBase, mode), r, imm});
        writeReg(mode, r, immOperand(mode, imm));
    endtask

    task automatic loadReg(laneMode_t mode, regIdx_t r);
        addr_t addr;
        addr = addr_t'($unsigned($random(seed)) % StoreBase);
        emit({withMode(OpLoadBase, mode), r, imm_t'(addr)});
        expLoadAddr.push_back(addr);
        writeReg(mode, r, dataMem[addr]);
    endtask

    task automatic storeReg(laneMode_t mode, regIdx_t r);
        addr_t addr;
        addr = addr_t'(nextStore);
        nextStore++;
        emit({withMode(OpStoreBase, mode), r, imm_t'(addr)});
        expStoreAddr.push_back(addr);
        expStoreData.push_back(readReg(mode, r));
    endtask

    // register form, rb is destination and first operand
    task automatic regFormOp(opcode_t base, aluOp_t op, laneMode_t mode, regIdx_t rb, regIdx_t rc);
        emit({withMode(base, mode), 2'b00, 6'b0, rb, rc});
        writeReg(mode, rb, laneCompute(op, mode, readReg(mode, rb), readReg(mode, rc)));
    endtask

    task automatic immFormOp(opcode_t base, aluOp_t op, laneMode_t mode, regIdx_t ra, imm_t imm);
        emit({withMode(base + 6'd3, mode), ra, imm});
        writeReg(mode, ra, laneCompute(op, mode, readReg(mode, ra), immOperand(mode, imm)));
    endtask

    task automatic invertReg(laneMode_t mode, regIdx_t rc);
        emit({withMode(OpNotBase, mode), 2'b00, 8'b0, rc});
        writeReg(mode, rc, laneCompute(aluNot, mode, readReg(mode, rc), '0));
    endtask

    task automatic buildProgram();
        laneMode_t mode;
        int mi;
        for (mi = 0; mi < 4; mi++)
        begin
            mH[mi] = '0;
            mO[mi] = '0;
            mQ[mi] = '0;
        end
        for (mi = 0; mi < 3; mi++)
        begin
            mode = laneMode_t'(mi);
            setReg(mode, 2'd0, randImm());
            storeReg(mode, 2'd0);
            setReg(mode, 2'd3, randImm()); // O and Q drop this write
            storeReg(mode, 2'd3);
            loadReg(mode, 2'd0);
            loadReg(mode, 2'd1);
            loadReg(mode, 2'd2);
            storeReg(mode, 2'd1);
            regFormOp(OpAddBase, aluAdd, mode, 2'd0, 2'd1);
            storeReg(mode, 2'd0);
            regFormOp(OpSubBase, aluSub, mode, 2'd2, 2'd1);
            storeReg(mode, 2'd2);
            immFormOp(OpAddBase, aluAdd, mode, 2'd1, randImm());
            storeReg(mode, 2'd1);
            immFormOp(OpSubBase, aluSub, mode, 2'd0, randImm());
            storeReg(mode, 2'd0);
            regFormOp(OpAndBase, aluAnd, mode, 2'd1, 2'd2);
            storeReg(mode, 2'd1);
            regFormOp(OpOrBase, aluOr, mode, 2'd0, 2'd2);
            storeReg(mode, 2'd0);
            invertReg(mode, 2'd2);
            storeReg(mode, 2'd2);
            emit({6'd12, regIdx_t'($random(seed)), randImm()}); // dropped opcode
            storeReg(mode, 2'd0);
            storeReg(mode, 2'd1);
            storeReg(mode, 2'd2);
        end
        haltAddr = addr_t'(progLen);
        emit({OpHalt, 12'b0});
    endtask

    always @(negedge clk)
    begin
        if (rst)
        begin
            if (cycle > 0)
            begin
                assert (instructionAddr == '0)
                else
                begin
                    mismatchCount++;
                    $display("mismatch instructionAddr in reset: got %h expected 000",
                             instructionAddr);
                end
                assert (!done && !dataR && !dataW)
                else
                begin
                    otherCount++;
                    $display("done or a data strobe is high during reset");
                end
            end
        end
        else
        begin
            if (!pcMoved && instructionAddr != '0)
            begin
                pcMoved = 1'b1;
                assert (cycle == ResetCycles + 6) // one idle cycle and five for the first instr
                else
                begin
                    otherCount++;
                    $display("first instruction address change at cycle %0d, expected %0d",
                             cycle, ResetCycles + 6);
                end
            end
            if (dataR && !prevR)
            begin
                assert (expLoadAddr.size() != 0)
                else
                begin
                    otherCount++;
                    $display("unexpected load strobe at address %h", dataAddr);
                end
                if (expLoadAddr.size() != 0)
                begin
                    assert (dataAddr == expLoadAddr[0])
                    else
                    begin
                        mismatchCount++;
                        $display("mismatch dataAddr on load: got %h expected %h",
                                 dataAddr, expLoadAddr[0]);
                    end
                    void'(expLoadAddr.pop_front());
                end
            end
            if (dataW && !prevW)
            begin
                assert (expStoreAddr.size() != 0)
                else
                begin
                    otherCount++;
                    $display("unexpected store strobe at address %h", dataAddr);
                end
                if (expStoreAddr.size() != 0)
                begin
                    assert (dataAddr == expStoreAddr[0])
                    else
                    begin
                        mismatchCount++;
                        $display("mismatch dataAddr on store: got %h expected %h",
                                 dataAddr, expStoreAddr[0]);
                    end
                    assert (dataOut == expStoreData[0])
                    else
                    begin
                        mismatchCount++;
                        $display("mismatch dataOut at %h: got %h expected %h",
                                 expStoreAddr[0], dataOut, expStoreData[0]);
                    end
                    void'(expStoreAddr.pop_front());
                    void'(expStoreData.pop_front());
                end
            end
            if (haltFetchCycle < 0 && instructionAddr == haltAddr)
            begin
                haltFetchCycle = cycle; // fetch of halt starts here
            end
            if (done && !doneSeen)
            begin
                doneSeen = 1'b1;
                assert (cycle == haltFetchCycle + 2)
                else
                begin
                    otherCount++;
                    $display("done rose at cycle %0d, expected cycle %0d",
                             cycle, haltFetchCycle + 2);
                end
            end
            if (doneSeen)
            begin
                assert (instructionAddr == haltAddr)
                else
                begin
                    mismatchCount++;
                    $display("mismatch instructionAddr after halt: got %h expected %h",
                             instructionAddr, haltAddr);
                end
                assert (!dataR && !dataW)
                else
                begin
                    otherCount++;
                    $display("data strobe raised after halt");
                end
            end
        end
        prevR = dataR;
        prevW = dataW;
    end

    initial
    begin
        clk = 1'b0;
        rst = 1'b1;
        for (int i = 0; i < MemDepth; i++)
        begin
            dataMem[i] = word_t'($random(seed));
            prog[i] = {OpStoreBase, 2'd0, imm_t'(i)}; // only runs if halt fails
        end
        buildProgram();
        limit = ResetCycles + 1 + 5 * progLen + 20;
        repeat (ResetCycles) @(posedge clk);
        rst <= 1'b0;
        while (!done && cycle < limit)
        begin
            @(negedge clk);
        end
        if (!done)
        begin
            otherCount++;
            $display("timeout: done did not rise within %0d cycles", limit);
        end
        else
        begin
            repeat (20) @(negedge clk); // watch the halted core
        end
        @(posedge clk);
        assert (expStoreAddr.size() == 0 && expLoadAddr.size() == 0)
        else
        begin
            otherCount++;
            $display("%0d stores and %0d loads never happened",
                     expStoreAddr.size(), expLoadAddr.size());
        end
        $display("errors: %0d mismatches, %0d other failures", mismatchCount, otherCount);
        if (mismatchCount == 0 && otherCount == 0)
        begin
            $display("All tests passed!");
        end
        else
        begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* verilog.f */
source/simdPkg.sv
source/cpuControl.sv
source/instrDecode.sv
source/operandSelect.sv
source/laneSlice.sv
source/simdRegFile.sv
source/simdCpuTop.sv
sim/simdCpuProps.sv
sim/simdCpuTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= simdCpuTb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
